// File: include/cache_defs.svh
// cache geometry and address map macros
// derived set, block and tag field widths
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// data word width in bits
`define WORD_W          32
// total data capacity in bytes
`define CACHE_BYTES     256
// words per block
`define BLOCK_WORDS     2
// addresses from here up bypass the cache
`define NONCACHE_START  32'hF000_0000

// derived geometry, one frame per set
`define N_SETS      (`CACHE_BYTES / (`BLOCK_WORDS * `WORD_W / 8))
`define SET_BITS    ($clog2(`N_SETS))
`define BLOCK_BITS  ($clog2(`BLOCK_WORDS))
`define TAG_BITS    (`WORD_W - `SET_BITS - `BLOCK_BITS - 2)

`endif

// File: source/cache_types_pkg.sv
// cache geometry types
// address decode, stored frame layout and controller states
`include "cache_defs.svh"

package cache_types_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef word_t [`BLOCK_WORDS-1:0] block_t;
    typedef logic [`TAG_BITS-1:0]   tag_bits_t;
    typedef logic [`SET_BITS-1:0]   set_idx_t;
    typedef logic [`BLOCK_BITS-1:0] block_off_t;
    typedef logic [3:0]             byte_en_t;

    // processor address split into cache fields
    typedef struct packed {
        tag_bits_t  tag;
        set_idx_t   set_idx;
        block_off_t offset;
        logic [1:0] byte_bits;
    } decoded_addr_t;

    typedef struct packed {
        logic      valid;
        logic      dirty;
        tag_bits_t tag;
    } frame_tag_t;

    typedef struct packed {
        frame_tag_t tag;
        block_t     data;
    } frame_t;

    typedef enum logic [2:0] {
        IDLE, HIT, FETCH, WB, FLUSH_CACHE
    } cache_state_t;

endpackage

// File: source/bus_types_pkg.sv
// processor and memory bus request and response structs
package bus_types_pkg;
    import cache_types_pkg::*;

    // processor side, one word per access
    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } proc_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } proc_rsp_t;

    // memory side moves whole blocks
    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        block_t   wdata;
        byte_en_t byte_en;
    } mem_req_t;

    typedef struct packed {
        logic   busy;
        block_t rdata;
    } mem_rsp_t;

endpackage

// File: source/cache_array.sv
// frame storage for the direct-mapped cache
// combinational read, bit-masked synchronous write
`include "cache_defs.svh"

module cache_array (
    input  logic                      CLK,
    input  logic                      nRST,
    input  cache_types_pkg::set_idx_t sel,
    input  logic                      wen,
    input  cache_types_pkg::frame_t   wdata,
    input  cache_types_pkg::frame_t   wmask,
    output cache_types_pkg::frame_t   rdata
);
    import cache_types_pkg::*;

    frame_t frames [`N_SETS];

    // mask bit low means take the new bit
    always_ff @(posedge CLK) begin
        if (wen) begin
            frames[sel] <= (frames[sel] & wmask) | (wdata & ~wmask);
        end
    end

    assign rdata = frames[sel];

    // writes must land on an existing set
    a_sel_in_range: assert property (@(posedge CLK) disable iff (!nRST)
        wen |-> (sel < `N_SETS));

endmodule

// File: source/flush_walker.sv
// set counter shared by the reset clear and the flush
// finish is registered and held until restart
`include "cache_defs.svh"

module flush_walker (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      step,
    input  logic                      restart,
    output cache_types_pkg::set_idx_t set_num,
    output logic                      finish
);
    import cache_types_pkg::*;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            set_num <= '0;
            finish  <= 1'b0;
        end else if (restart) begin
            set_num <= '0;
            finish  <= 1'b0;
        end else if (step) begin
            // wrap past the last set
            if (set_num == set_idx_t'(`N_SETS - 1)) begin
                set_num <= '0;
                finish  <= 1'b1;
            end else begin
                set_num <= set_num + 1'b1;
            end
        end
    end

    a_step_restart_excl: assert property (@(posedge CLK) disable iff (!nRST)
        !(step && restart));

endmodule

// File: source/byte_lanes.sv
// byte-enable handling for the processor word
// hit write data and mask, fill merge, pass-through lanes
module byte_lanes (
    input  bus_types_pkg::proc_req_t    req,
    input  cache_types_pkg::block_off_t offset,
    input  cache_types_pkg::block_t     fill,
    output cache_types_pkg::block_t     hit_data,
    output cache_types_pkg::block_t     hit_mask,
    output cache_types_pkg::block_t     fill_data,
    output cache_types_pkg::word_t      pt_wdata
);
    import cache_types_pkg::*;

    always_comb begin
        hit_data         = '0;
        hit_mask         = '1;
        fill_data        = fill;
        pt_wdata         = '0;
        // word lands in the slot picked by the block bits
        hit_data[offset] = req.wdata;

        for (int i = 0; i < 4; i++) begin
            if (req.byte_en[i]) begin
                // open this byte for the hit write
                hit_mask[offset][i*8 +: 8] = 8'h00;
                pt_wdata[i*8 +: 8]         = req.wdata[i*8 +: 8];
                // write miss overlays its bytes on the fetched block
                if (req.wen) begin
                    fill_data[offset][i*8 +: 8] = req.wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

// File: source/cache_controller.sv
// direct-mapped write-back cache controller
// hit detection, pass-through, victim write-back, fill and flush sequencing
`include "cache_defs.svh"

module cache_controller (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      flush,
    output logic                      flush_done,
    input  bus_types_pkg::proc_req_t  proc_req,
    output bus_types_pkg::proc_rsp_t  proc_rsp,
    output bus_types_pkg::mem_req_t   mem_req,
    input  bus_types_pkg::mem_rsp_t   mem_rsp,
    output cache_types_pkg::set_idx_t sel,
    output logic                      wen,
    output cache_types_pkg::frame_t   wdata,
    output cache_types_pkg::frame_t   wmask,
    input  cache_types_pkg::frame_t   rdata,
    output logic                      step,
    output logic                      restart,
    input  cache_types_pkg::set_idx_t set_num,
    input  logic                      finish,
    input  cache_types_pkg::block_t   hit_data,
    input  cache_types_pkg::block_t   hit_mask,
    input  cache_types_pkg::block_t   fill_data,
    input  cache_types_pkg::word_t    pt_wdata
);
    import cache_types_pkg::*;

    cache_state_t  state, next_state;
    decoded_addr_t dec, miss_addr;
    logic          miss_load;
    logic          flush_req, flush_pend;
    logic          hit, pass_through, access, line_dirty;

    assign dec          = decoded_addr_t'(proc_req.addr);
    assign pass_through = proc_req.addr >= `NONCACHE_START;
    assign access       = proc_req.ren || proc_req.wen;
    assign hit          = !pass_through && rdata.tag.valid && (rdata.tag.tag == dec.tag);
    assign line_dirty   = rdata.tag.valid && rdata.tag.dirty;
    assign flush_pend   = flush || flush_req;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            flush_req <= 1'b0;
        end else begin
            state     <= next_state;
            // kept from the pulse until the flush is served
            flush_req <= flush_pend && !flush_done;
        end
    end

    always_ff @(posedge CLK) begin
        if (miss_load) begin
            miss_addr <= dec;
        end
    end

    // set select: walker, pending miss or live request
    always_comb begin
        case (state)
            IDLE, FLUSH_CACHE: sel = set_num;
            WB, FETCH:         sel = miss_addr.set_idx;
            default:           sel = dec.set_idx;
        endcase
    end

    always_comb begin
        next_state      = state;
        wen             = 1'b0;
        wdata           = '0;
        wmask           = '1;
        step            = 1'b0;
        restart         = 1'b0;
        flush_done      = 1'b0;
        miss_load       = 1'b0;
        proc_rsp.busy   = 1'b1;
        proc_rsp.rdata  = '0;
        mem_req.ren     = 1'b0;
        mem_req.wen     = 1'b0;
        mem_req.addr    = '0;
        mem_req.wdata   = '0;
        mem_req.byte_en = '1;

        case (state)
            IDLE: begin
                // zero one set per cycle after reset
                if (finish) begin
                    restart    = 1'b1;
                    next_state = HIT;
                end else begin
                    wen   = 1'b1;
                    wmask = '0;
                    step  = 1'b1;
                end
            end
            HIT: begin
                if (pass_through && access) begin
                    // word rides in its own slot of the block
                    mem_req.ren               = proc_req.ren;
                    mem_req.wen               = proc_req.wen;
                    mem_req.addr              = proc_req.addr;
                    mem_req.byte_en           = proc_req.byte_en;
                    mem_req.wdata[dec.offset] = pt_wdata;
                    proc_rsp.busy             = mem_rsp.busy;
                    proc_rsp.rdata            = mem_rsp.rdata[dec.offset];
                end else if (flush_pend) begin
                    next_state = FLUSH_CACHE;
                end else if (proc_req.ren && hit) begin
                    proc_rsp.busy  = 1'b0;
                    proc_rsp.rdata = rdata.data[dec.offset];
                end else if (proc_req.wen && hit) begin
                    proc_rsp.busy   = 1'b0;
                    wen             = 1'b1;
                    wdata.data      = hit_data;
                    wmask.data      = hit_mask;
                    wdata.tag.dirty = 1'b1;
                    wmask.tag.dirty = 1'b0;
                end else if (access) begin
                    miss_load  = 1'b1;
                    next_state = line_dirty ? WB : FETCH;
                end
            end
            WB: begin
                // evict the old block to its own address
                mem_req.wen   = 1'b1;
                mem_req.addr  = {rdata.tag.tag, miss_addr.set_idx, block_off_t'(0), 2'b00};
                mem_req.wdata = rdata.data;
                if (!mem_rsp.busy) begin
                    wen             = 1'b1;
                    wmask.tag.dirty = 1'b0;
                    next_state      = FETCH;
                end
            end
            FETCH: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = {miss_addr.tag, miss_addr.set_idx, block_off_t'(0), 2'b00};
                if (!mem_rsp.busy) begin
                    wen             = 1'b1;
                    wmask           = '0;
                    wdata.tag.valid = 1'b1;
                    // a merged write miss leaves the line dirty
                    wdata.tag.dirty = proc_req.wen;
                    wdata.tag.tag   = miss_addr.tag;
                    wdata.data      = fill_data;
                    next_state      = HIT;
                end
            end
            FLUSH_CACHE: begin
                if (finish) begin
                    flush_done = 1'b1;
                    restart    = 1'b1;
                    next_state = HIT;
                end else if (line_dirty) begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = {rdata.tag.tag, set_num, block_off_t'(0), 2'b00};
                    mem_req.wdata = rdata.data;
                    if (!mem_rsp.busy) begin
                        wen   = 1'b1;
                        wmask = '0;
                        step  = 1'b1;
                    end
                end else begin
                    // clean or empty, just clear it
                    wen   = 1'b1;
                    wmask = '0;
                    step  = 1'b1;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    a_mem_single_strobe: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen));

endmodule

// File: source/l1_cache.sv
// L1 data cache top level
// controller, frame array, set walker and byte lanes
`include "cache_defs.svh"

module l1_cache (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     flush,
    output logic                     flush_done,
    input  bus_types_pkg::proc_req_t proc_req,
    output bus_types_pkg::proc_rsp_t proc_rsp,
    output bus_types_pkg::mem_req_t  mem_req,
    input  bus_types_pkg::mem_rsp_t  mem_rsp
);
    import cache_types_pkg::*;

    set_idx_t arr_sel, walk_set;
    logic     arr_wen, walk_step, walk_restart, walk_finish;
    frame_t   arr_wdata, arr_wmask, arr_rdata;
    block_t   lane_hit_data, lane_hit_mask, lane_fill_data;
    word_t    lane_pt_wdata;

    cache_controller ctrl (
        .CLK(CLK), .nRST(nRST), .flush(flush), .flush_done(flush_done),
        .proc_req(proc_req), .proc_rsp(proc_rsp), .mem_req(mem_req), .mem_rsp(mem_rsp),
        .sel(arr_sel), .wen(arr_wen), .wdata(arr_wdata), .wmask(arr_wmask),
        .rdata(arr_rdata), .step(walk_step), .restart(walk_restart),
        .set_num(walk_set), .finish(walk_finish), .hit_data(lane_hit_data),
        .hit_mask(lane_hit_mask), .fill_data(lane_fill_data), .pt_wdata(lane_pt_wdata)
    );

    cache_array array (
        .CLK(CLK), .nRST(nRST), .sel(arr_sel), .wen(arr_wen),
        .wdata(arr_wdata), .wmask(arr_wmask), .rdata(arr_rdata)
    );

    flush_walker walker (
        .CLK(CLK), .nRST(nRST), .step(walk_step), .restart(walk_restart),
        .set_num(walk_set), .finish(walk_finish)
    );

    // word offset comes straight from the block bits of the request
    byte_lanes lanes (
        .req(proc_req), .offset(proc_req.addr[`BLOCK_BITS+1:2]), .fill(mem_rsp.rdata),
        .hit_data(lane_hit_data), .hit_mask(lane_hit_mask),
        .fill_data(lane_fill_data), .pt_wdata(lane_pt_wdata)
    );

endmodule

// File: bench/mem_model.sv
// block-wide memory model for the cache testbench
// random busy latency per transfer, words start equal to their address
`include "cache_defs.svh"

module mem_model (
    input  logic                    CLK,
    input  logic                    nRST,
    input  bus_types_pkg::mem_req_t req,
    output bus_types_pkg::mem_rsp_t rsp
);
    timeunit 1ns;
    timeprecision 1ps;
    import cache_types_pkg::*;

    localparam int MEM_WORDS = 512;

    word_t      store [MEM_WORDS];
    logic [2:0] wait_cnt, wait_len;
    logic       active, cacheable;
    logic [8:0] base_even, base_odd;

    assign active    = req.ren || req.wen;
    assign cacheable = req.addr < `NONCACHE_START;
    assign base_even = {req.addr[10:3], 1'b0};
    assign base_odd  = {req.addr[10:3], 1'b1};

    assign rsp.busy     = active && (wait_cnt != wait_len);
    assign rsp.rdata[0] = store[base_even];
    assign rsp.rdata[1] = store[base_odd];

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            store[i] = word_t'(i * 4);
        end
    end

    // busy until the drawn latency has passed, then one ready cycle
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
            wait_len <= 3'd1;
        end else if (!active) begin
            wait_cnt <= '0;
        end else if (wait_cnt == wait_len) begin
            // pass-through writes never reach the backing array
            if (req.wen && cacheable) begin
                store[base_even] <= req.wdata[0];
                store[base_odd]  <= req.wdata[1];
            end
            wait_cnt <= '0;
            wait_len <= 3'(1 + ($urandom % 4));
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

endmodule

// File: bench/l1_cache_tb.sv
// testbench for the L1 data cache
// clock, reset, shadow memory, access tasks, bus monitors and watchdog
`include "cache_defs.svh"

module l1_cache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cache_types_pkg::*;
    import bus_types_pkg::*;

    localparam int MEM_WORDS   = 512;
    localparam int N_RANDOM    = 60;
    localparam int PLANNED     = 1 + 3 * N_RANDOM + 8 + `N_SETS;
    localparam int WATCHDOG_NS = (PLANNED * 40 + 16) * 100;

    logic      CLK = 1'b0;
    logic      nRST;
    logic      flush;
    logic      flush_done;
    proc_req_t proc_req;
    proc_rsp_t proc_rsp;
    mem_req_t  mem_req;
    mem_rsp_t  mem_rsp;

    word_t shadow [MEM_WORDS];
    logic  written [MEM_WORDS];
    int    errors = 0;
    int    done_pulses = 0;
    word_t last_wb_addr;
    logic  wb_seen;

    always #50 CLK = ~CLK;

    l1_cache UUT (
        .CLK(CLK), .nRST(nRST), .flush(flush), .flush_done(flush_done),
        .proc_req(proc_req), .proc_rsp(proc_rsp), .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    mem_model mem (.CLK(CLK), .nRST(nRST), .req(mem_req), .rsp(mem_rsp));

    function automatic word_t byte_mask(input byte_en_t be);
        word_t m;
        m = '0;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) m[i*8 +: 8] = 8'hFF;
        end
        return m;
    endfunction

    // one processor access, held until busy drops
    task automatic run_access(input string name, input logic rd, input word_t addr,
                              input word_t wd, input byte_en_t be,
                              output word_t rdata, output int cycles);
        block_t exp_blk;
        exp_blk = '0;
        exp_blk[addr[2]] = wd & byte_mask(be);
        @(posedge CLK);
        proc_req.ren     <= rd;
        proc_req.wen     <= !rd;
        proc_req.addr    <= addr;
        proc_req.wdata   <= wd;
        proc_req.byte_en <= be;
        cycles = 0;
        do begin
            @(negedge CLK);
            cycles++;
            if (addr >= `NONCACHE_START) begin
                assert (mem_req.addr == addr) else begin
                    errors++;
                    $display("Mismatch %s addr: expected %h, actual %h", name, addr, mem_req.addr);
                end
                assert (mem_req.ren == rd && mem_req.wen == !rd) else begin
                    errors++;
                    $display("Mismatch %s strobes: expected %b%b, actual %b%b",
                             name, rd, !rd, mem_req.ren, mem_req.wen);
                end
                assert (mem_req.byte_en == be) else begin
                    errors++;
                    $display("Mismatch %s byte_en: expected %h, actual %h",
                             name, be, mem_req.byte_en);
                end
                if (!rd) begin
                    assert (mem_req.wdata == exp_blk) else begin
                        errors++;
                        $display("Mismatch %s lanes: expected %h, actual %h",
                                 name, exp_blk, mem_req.wdata);
                    end
                end
            end
        end while (proc_rsp.busy);
        rdata = proc_rsp.rdata;
        if (!rd && addr < `NONCACHE_START) begin
            shadow[addr[10:2]]  = (shadow[addr[10:2]] & ~byte_mask(be)) | (wd & byte_mask(be));
            written[addr[10:2]] = 1'b1;
        end
        @(posedge CLK);
        proc_req.ren <= 1'b0;
        proc_req.wen <= 1'b0;
    endtask

    task automatic read_check(input string name, input word_t addr, input logic expect_hit);
        word_t rdata;
        int    cycles;
        run_access(name, 1'b1, addr, '0, 4'hF, rdata, cycles);
        assert (rdata == shadow[addr[10:2]]) else begin
            errors++;
            $display("Mismatch %s data: expected %h, actual %h", name, shadow[addr[10:2]], rdata);
        end
        if (expect_hit) begin
            assert (cycles == 1) else begin
                errors++;
                $display("Mismatch %s hit cycles: expected 1, actual %0d", name, cycles);
            end
        end
    endtask

    task automatic write_word(input string name, input word_t addr, input word_t wd,
                              input byte_en_t be);
        word_t rdata;
        int    cycles;
        run_access(name, 1'b0, addr, wd, be, rdata, cycles);
    endtask

    // every cacheable block write-back must carry the shadow contents
    always @(negedge CLK) begin
        if (nRST && mem_req.wen && !mem_rsp.busy && mem_req.addr < `NONCACHE_START) begin
            last_wb_addr = mem_req.addr;
            wb_seen      = 1'b1;
            for (int w = 0; w < 2; w++) begin
                assert (mem_req.wdata[w] == shadow[{mem_req.addr[10:3], w[0]}]) else begin
                    errors++;
                    $display("Mismatch writeback word %0d: expected %h, actual %h", w,
                             shadow[{mem_req.addr[10:3], w[0]}], mem_req.wdata[w]);
                end
            end
        end
    end

    always @(posedge CLK) begin
        if (flush_done) done_pulses <= done_pulses + 1;
    end

    initial begin
        #(WATCHDOG_NS * 1ns);
        $display("watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

    initial begin
        word_t addr;
        void'($urandom(20));
        nRST     = 1'b0;
        flush    = 1'b0;
        proc_req = '0;
        wb_seen  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i]  = word_t'(i * 4);
            written[i] = 1'b0;
        end
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;

        // cache clears its sets with the buses quiet
        repeat (`N_SETS) begin
            @(negedge CLK);
            assert (proc_rsp.busy && !mem_req.ren && !mem_req.wen && !flush_done) else begin
                errors++;
                $display("bus activity or ready cache during the reset clear");
            end
        end
        read_check("reset_clear", 32'h0000_0040, 1'b0);

        for (int n = 0; n < N_RANDOM; n++) begin
            addr = word_t'(($urandom % MEM_WORDS) * 4);
            write_word("rand_write", addr, $urandom, 4'($urandom % 16));
            read_check("rand_read", addr, 1'b0);
            read_check("rand_reread", addr ^ 32'h4, 1'b1);
        end

        // same set, different tag
        write_word("evict_write", 32'h0000_0128, 32'hCAFE_F00D, 4'hF);
        wb_seen = 1'b0;
        read_check("evict_read", 32'h0000_0228, 1'b0);
        assert (wb_seen && last_wb_addr == 32'h0000_0128) else begin
            errors++;
            $display("Mismatch evict addr: expected %h, actual %h", 32'h0000_0128, last_wb_addr);
        end

        write_word("pt_write", 32'hF000_0104, 32'hA1B2_C3D4, 4'b0101);
        write_word("pt_write_lo", 32'hF000_0100, 32'h1122_3344, 4'b1010);
        read_check("pt_after", 32'h0000_0228, 1'b1);

        @(posedge CLK);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        while (done_pulses == 0) @(posedge CLK);
        repeat (8) @(posedge CLK);
        assert (done_pulses == 1) else begin
            errors++;
            $display("Mismatch flush_done pulses: expected 1, actual %0d", done_pulses);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (written[i]) begin
                assert (mem.store[i] == shadow[i]) else begin
                    errors++;
                    $display("Mismatch flush word %0d: expected %h, actual %h",
                             i, shadow[i], mem.store[i]);
                end
            end
        end

        // memory is up to date now, so an uncached read sees the shadow word
        read_check("pt_read", 32'hF000_0104, 1'b0);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
source/cache_types_pkg.sv
source/bus_types_pkg.sv
source/cache_array.sv
source/flush_walker.sv
source/byte_lanes.sv
source/cache_controller.sv
source/l1_cache.sv
bench/mem_model.sv
bench/l1_cache_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing
TOP      := l1_cache_tb
FILELIST := all.f
SOURCES  := $(wildcard source/*.sv bench/*.sv include/*.svh)
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee run.log
	grep -q "Everything OK" run.log

clean:
	rm -rf obj_dir run.log
